// ==== hw/execPkg.sv ====
package execPkg;

    // data widths
    typedef logic [31:0] word_t;
    typedef logic [63:0] dword_t;
    typedef logic [4:0]  shamt_t;

    // operation codes, one per supported instruction
    // immediate trap forms reuse the register codes
    typedef enum logic [5:0] {
        opNop   = 6'd0,
        opAnd   = 6'd1,  opOr    = 6'd2,  opNor   = 6'd3,  opXor   = 6'd4,
        opAdd   = 6'd5,  opAddu  = 6'd6,  opSub   = 6'd7,  opSubu  = 6'd8,
        opSlt   = 6'd9,  opSltu  = 6'd10,
        opSll   = 6'd11, opSrl   = 6'd12, opSra   = 6'd13,
        opSllv  = 6'd14, opSrlv  = 6'd15, opSrav  = 6'd16,
        opLui   = 6'd17, opClo   = 6'd18, opClz   = 6'd19,
        opMovn  = 6'd20, opMovz  = 6'd21,
        opTeq   = 6'd22, opTne   = 6'd23, opTge   = 6'd24,
        opTgeu  = 6'd25, opTlt   = 6'd26, opTltu  = 6'd27,
        opMult  = 6'd28, opMultu = 6'd29, opMul   = 6'd30,
        opMadd  = 6'd31, opMaddu = 6'd32, opMsub  = 6'd33, opMsubu = 6'd34,
        opDiv   = 6'd35, opDivu  = 6'd36,
        opMthi  = 6'd37, opMtlo  = 6'd38, opMfhi  = 6'd39, opMflo  = 6'd40
    } aluOp_e;

    // operands for the multiplier and divider
    typedef struct packed {
        word_t a;
        word_t b;
        logic  isSigned;
    } mulDivReq_t;

    // HI/LO update, value[63:32] goes to HI
    typedef struct packed {
        logic   wrHi;
        logic   wrLo;
        dword_t value;
    } hiLoWr_t;

endpackage

// ==== hw/aluCore.sv ====
`timescale 1ns/1ps

module aluCore import execPkg::*; (
    input  aluOp_e op_i,
    input  word_t  srcA_i,
    input  word_t  srcB_i,
    input  shamt_t shamt_i,
    input  dword_t hiLo_i,
    output word_t  result_o,
    output logic   overflow_o,
    output logic   trap_o
);

    word_t sum;
    word_t diff;
    word_t clzCount;
    word_t cloCount;

    // number of zero bits above the first one
    function automatic word_t leadZeros(word_t v);
        word_t n;
        logic  found;
        n = '0;
        found = 1'b0;
        for (int i = 31; i >= 0; i--) begin
            if (!found) begin
                if (v[i]) begin
                    found = 1'b1;
                end else begin
                    n = n + 1;
                end
            end
        end
        return n;
    endfunction

    assign sum = srcA_i + srcB_i;
    assign diff = srcA_i - srcB_i;
    assign clzCount = leadZeros(srcA_i);
    // leading ones are leading zeros of the inverse
    assign cloCount = leadZeros(~srcA_i);

    always_comb begin
        result_o = '0;
        overflow_o = 1'b0;
        case (op_i)
            opNop:   result_o = srcA_i;
            opAnd:   result_o = srcA_i & srcB_i;
            opOr:    result_o = srcA_i | srcB_i;
            opNor:   result_o = ~(srcA_i | srcB_i);
            opXor:   result_o = srcA_i ^ srcB_i;
            opAdd: begin
                result_o = sum;
                // same operand signs, result sign flipped
                overflow_o = (srcA_i[31] == srcB_i[31]) && (sum[31] != srcA_i[31]);
            end
            opAddu:  result_o = sum;
            opSub: begin
                result_o = diff;
                overflow_o = (srcA_i[31] != srcB_i[31]) && (diff[31] != srcA_i[31]);
            end
            opSubu:  result_o = diff;
            opSlt:   result_o = word_t'($signed(srcA_i) < $signed(srcB_i));
            opSltu:  result_o = word_t'(srcA_i < srcB_i);
            opSll:   result_o = srcB_i << shamt_i;
            opSrl:   result_o = srcB_i >> shamt_i;
            opSra:   result_o = $signed(srcB_i) >>> shamt_i;
            opSllv:  result_o = srcB_i << srcA_i[4:0];
            opSrlv:  result_o = srcB_i >> srcA_i[4:0];
            opSrav:  result_o = $signed(srcB_i) >>> srcA_i[4:0];
            opLui:   result_o = {srcB_i[15:0], 16'h0000};
            opClo:   result_o = cloCount;
            opClz:   result_o = clzCount;
            opMovn:  result_o = (srcB_i != '0) ? srcA_i : '0;
            opMovz:  result_o = (srcB_i == '0) ? srcA_i : '0;
            opMfhi:  result_o = hiLo_i[63:32];
            opMflo:  result_o = hiLo_i[31:0];
            // multi-cycle ops, traps and HI/LO moves return zero
            default: result_o = '0;
        endcase
    end

    // trap conditions, immediate forms arrive on srcB
    always_comb begin
        case (op_i)
            opTeq:   trap_o = srcA_i == srcB_i;
            opTne:   trap_o = srcA_i != srcB_i;
            opTge:   trap_o = $signed(srcA_i) >= $signed(srcB_i);
            opTgeu:  trap_o = srcA_i >= srcB_i;
            opTlt:   trap_o = $signed(srcA_i) < $signed(srcB_i);
            opTltu:  trap_o = srcA_i < srcB_i;
            default: trap_o = 1'b0;
        endcase
    end

endmodule

// ==== hw/mulUnit.sv ====
`timescale 1ns/1ps

module mulUnit import execPkg::*; #(
    parameter int MulLatency = 2
) (
    input  logic       clk_i,
    input  logic       reset_i,
    input  logic       flush_i,
    input  logic       start_i,
    input  mulDivReq_t req_i,
    output logic       ready_o,
    output dword_t     product_o
);

    logic signed [32:0] aExt;
    logic signed [32:0] bExt;
    logic signed [65:0] prodFull;
    dword_t             stageQ [MulLatency];
    logic [MulLatency-1:0] validQ;
    logic               startQ;
    logic               accept;

    // extend by sign or zero, then one signed multiply covers both
    assign aExt = {req_i.isSigned & req_i.a[31], req_i.a};
    assign bExt = {req_i.isSigned & req_i.b[31], req_i.b};
    assign prodFull = aExt * bExt;

    // start is held until ready, so only its first cycle enters the pipe
    assign accept = start_i & ~startQ & ~flush_i;

    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            startQ <= 1'b0;
            validQ <= '0;
        end else begin
            startQ <= start_i;
            validQ <= (validQ << 1) | MulLatency'(accept);
        end
    end

    always_ff @(posedge clk_i) begin
        stageQ[0] <= prodFull[63:0];
        for (int i = 1; i < MulLatency; i++) begin
            stageQ[i] <= stageQ[i-1];
        end
    end

    assign ready_o = validQ[MulLatency-1];
    assign product_o = stageQ[MulLatency-1];

endmodule

// ==== hw/divUnit.sv ====
`timescale 1ns/1ps

module divUnit import execPkg::*; (
    input  logic       clk_i,
    input  logic       reset_i,
    input  logic       flush_i,
    input  logic       start_i,
    input  mulDivReq_t req_i,
    output logic       ready_o,
    output dword_t     quotRem_o
);

    typedef enum logic [1:0] {
        stIdle,
        stRun,
        stFix
    } divState_e;

    divState_e   stateQ;
    logic [4:0]  stepQ;
    logic        readyQ;
    word_t       remQ;
    word_t       quotQ;
    word_t       divisorQ;
    logic        negQuotQ;
    logic        negRemQ;
    logic        negA;
    logic        negB;
    logic [32:0] remShift;
    logic [32:0] trial;

    assign negA = req_i.isSigned & req_i.a[31];
    assign negB = req_i.isSigned & req_i.b[31];

    // bring down the next dividend bit and try the subtract
    assign remShift = {remQ, quotQ[31]};
    assign trial = remShift - {1'b0, divisorQ};

    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            stateQ <= stIdle;
            readyQ <= 1'b0;
        end else begin
            readyQ <= 1'b0;
            case (stateQ)
                stIdle: if (start_i) stateQ <= stRun;
                stRun:  if (stepQ == 5'd31) stateQ <= stFix;
                stFix: begin
                    stateQ <= stIdle;
                    readyQ <= 1'b1;
                end
                default: stateQ <= stIdle;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        case (stateQ)
            stIdle: begin
                // setup, work on magnitudes
                remQ <= '0;
                quotQ <= negA ? -req_i.a : req_i.a;
                divisorQ <= negB ? -req_i.b : req_i.b;
                negQuotQ <= negA ^ negB;
                negRemQ <= negA;
                stepQ <= '0;
            end
            stRun: begin
                stepQ <= stepQ + 5'd1;
                if (!trial[32]) begin
                    remQ <= trial[31:0];
                    quotQ <= {quotQ[30:0], 1'b1};
                end else begin
                    remQ <= remShift[31:0];
                    quotQ <= {quotQ[30:0], 1'b0};
                end
            end
            default: begin
                // sign correction, remainder takes the dividend's sign
                quotRem_o <= {negRemQ ? -remQ : remQ, negQuotQ ? -quotQ : quotQ};
            end
        endcase
    end

    assign ready_o = readyQ;

endmodule

// ==== hw/hiLoRegs.sv ====
`timescale 1ns/1ps

module hiLoRegs import execPkg::*; (
    input  logic    clk_i,
    input  logic    reset_i,
    input  hiLoWr_t wr_i,
    output dword_t  hiLo_o
);

    word_t hiQ;
    word_t loQ;

    // each half has its own enable
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            hiQ <= '0;
            loQ <= '0;
        end else begin
            if (wr_i.wrHi) begin
                hiQ <= wr_i.value[63:32];
            end
            if (wr_i.wrLo) begin
                loQ <= wr_i.value[31:0];
            end
        end
    end

    assign hiLo_o = {hiQ, loQ};

endmodule

// ==== hw/execUnit.sv ====
`timescale 1ns/1ps

module execUnit import execPkg::*; #(
    parameter int MulLatency = 2
) (
    input  logic   clk_i,
    input  logic   reset_i,
    input  aluOp_e op_i,
    input  word_t  srcA_i,
    input  word_t  srcB_i,
    input  shamt_t shamt_i,
    input  logic   flush_i,
    input  logic   commitBlock_i,
    output word_t  result_o,
    output logic   overflow_o,
    output logic   trap_o,
    output logic   stall_o
);

    mulDivReq_t req;
    hiLoWr_t    hiLoWr;
    dword_t     hiLo;
    dword_t     product;
    dword_t     quotRem;
    word_t      aluResult;
    logic       isMul;
    logic       isDiv;
    logic       mulSigned;
    logic       mulReady;
    logic       divReady;
    logic       mulStart;
    logic       divStart;
    logic       mulWrites;
    logic       commitOk;

    always_comb begin
        isMul = 1'b0;
        isDiv = 1'b0;
        mulSigned = 1'b0;
        case (op_i)
            opMult, opMul, opMadd, opMsub: begin
                isMul = 1'b1;
                mulSigned = 1'b1;
            end
            opMultu, opMaddu, opMsubu: isMul = 1'b1;
            opDiv, opDivu:             isDiv = 1'b1;
            default: ;
        endcase
    end

    // MUL only returns the low word, HI/LO stays as is
    assign mulWrites = isMul && (op_i != opMul);

    assign req = '{a: srcA_i, b: srcB_i, isSigned: isMul ? mulSigned : (op_i == opDiv)};

    // start stays up until the unit answers, a flush kills it
    assign mulStart = isMul & ~mulReady & ~flush_i;
    assign divStart = isDiv & ~divReady & ~flush_i;
    assign stall_o = mulStart | divStart;

    assign commitOk = ~commitBlock_i & ~flush_i;

    always_comb begin
        hiLoWr = '0;
        case (op_i)
            opMult, opMultu: hiLoWr.value = product;
            opMadd, opMaddu: hiLoWr.value = hiLo + product;
            opMsub, opMsubu: hiLoWr.value = hiLo - product;
            opDiv, opDivu:   hiLoWr.value = quotRem;
            opMthi, opMtlo:  hiLoWr.value = {srcA_i, srcA_i};
            default:         hiLoWr.value = '0;
        endcase
        hiLoWr.wrHi = commitOk & ((mulWrites & mulReady) | (isDiv & divReady) | (op_i == opMthi));
        hiLoWr.wrLo = commitOk & ((mulWrites & mulReady) | (isDiv & divReady) | (op_i == opMtlo));
    end

    aluCore aluCore_i (
        .op_i       (op_i),
        .srcA_i     (srcA_i),
        .srcB_i     (srcB_i),
        .shamt_i    (shamt_i),
        .hiLo_i     (hiLo),
        .result_o   (aluResult),
        .overflow_o (overflow_o),
        .trap_o     (trap_o)
    );

    mulUnit #(
        .MulLatency (MulLatency)
    ) mulUnit_i (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .flush_i    (flush_i),
        .start_i    (mulStart),
        .req_i      (req),
        .ready_o    (mulReady),
        .product_o  (product)
    );

    divUnit divUnit_i (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .flush_i    (flush_i),
        .start_i    (divStart),
        .req_i      (req),
        .ready_o    (divReady),
        .quotRem_o  (quotRem)
    );

    hiLoRegs hiLoRegs_i (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .wr_i       (hiLoWr),
        .hiLo_o     (hiLo)
    );

    assign result_o = (op_i == opMul && mulReady) ? product[31:0] : aluResult;

endmodule

// ==== tests/execUnit_checker.sv ====
`timescale 1ns/1ps

module execUnit_checker import execPkg::*; (
    input logic   clk_i,
    input logic   reset_i,
    input aluOp_e op_i,
    input logic   overflow_i,
    input logic   trap_i,
    input logic   stall_i
);

    // consecutive cycles with stall high
    int stallCycles;

    always_ff @(posedge clk_i) begin
        if (reset_i || !stall_i) begin
            stallCycles <= 0;
        end else begin
            stallCycles <= stallCycles + 1;
        end
    end

    stallInReset: assert property (@(posedge clk_i) reset_i |-> !stall_i)
        else $error("stall high during reset");

    overflowOnlyAddSub: assert property (@(posedge clk_i) disable iff (reset_i)
        overflow_i |-> (op_i == opAdd || op_i == opSub))
        else $error("overflow raised by op %0d", op_i);

    trapOnlyTrapOps: assert property (@(posedge clk_i) disable iff (reset_i)
        trap_i |-> (op_i inside {opTeq, opTne, opTge, opTgeu, opTlt, opTltu}))
        else $error("trap raised by op %0d", op_i);

    // longest case is a divide, 34 cycles
    stallBounded: assert property (@(posedge clk_i) disable iff (reset_i) stallCycles < 40)
        else $error("stall held for 40 cycles");

endmodule

bind execUnit execUnit_checker execUnitChecker_i (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .op_i       (op_i),
    .overflow_i (overflow_o),
    .trap_i     (trap_o),
    .stall_i    (stall_o)
);

// ==== tests/execUnitTb.sv ====
`timescale 1ns/1ps

module execUnitTb import execPkg::*; ();

    localparam int ClkPeriod = 100;
    localparam int ResetCycles = 16;
    // outputs are read this long after the falling edge
    localparam int SampleDelay = 40;
    localparam int StallTimeout = 100;
    localparam int MulLatency = 2;
    // setup, 32 steps and sign correction
    localparam int DivLatency = 34;

    logic   clk;
    logic   reset;
    aluOp_e op;
    word_t  srcA;
    word_t  srcB;
    shamt_t shamt;
    logic   flush;
    logic   commitBlock;
    word_t  result;
    logic   overflow;
    logic   trap;
    logic   stall;

    execUnit #(
        .MulLatency (MulLatency)
    ) execUnit_i (
        .clk_i         (clk),
        .reset_i       (reset),
        .op_i          (op),
        .srcA_i        (srcA),
        .srcB_i        (srcB),
        .shamt_i       (shamt),
        .flush_i       (flush),
        .commitBlock_i (commitBlock),
        .result_o      (result),
        .overflow_o    (overflow),
        .trap_o        (trap),
        .stall_o       (stall)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    task automatic compareValue(input string testName, input string what,
                                input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERR %0s %0s expected %08h actual %08h", testName, what, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "%0s: %0s mismatch", testName, what);
        end
    endtask

    // cycles with stall high, multiply pipe depth or the full divide
    function automatic int expectedStallCycles(input logic [5:0] opCode);
        case (aluOp_e'(opCode))
            opMult, opMultu, opMul, opMadd, opMaddu, opMsub, opMsubu: return MulLatency;
            opDiv, opDivu: return DivLatency;
            default: return 0;
        endcase
    endfunction

    // ctl 1 kills the operation one cycle after it starts, ctl 2 blocks the commit
    task automatic issueOp(input logic [5:0] opCode, input word_t a, input word_t b,
                           input shamt_t sh, input logic [1:0] ctl);
        @(negedge clk);
        op = aluOp_e'(opCode);
        srcA = a;
        srcB = b;
        shamt = sh;
        flush = 1'b0;
        commitBlock = (ctl == 2'd2);
        if (ctl == 2'd1) begin
            @(negedge clk);
            flush = 1'b1;
        end
    endtask

    task automatic waitStallLow(input string testName, output int stallCycles);
        int cycles;
        cycles = 0;
        #(SampleDelay);
        while (stall) begin
            if (cycles >= StallTimeout) begin
                $display("TEST FAILED");
                $fatal(1, "%0s: stall never cleared within %0d cycles", testName, StallTimeout);
            end
            @(negedge clk);
            #(SampleDelay);
            cycles++;
        end
        stallCycles = cycles;
    endtask

    initial begin
        int          fd;
        int          lineNo;
        int          fields;
        int          testCount;
        int          stallCycles;
        string       line;
        string       testName;
        logic [31:0] opCode;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sh;
        logic [31:0] ctl;
        logic [31:0] expResult;
        logic [31:0] expOvf;
        logic [31:0] expTrap;
        clk = 1'b0;
        reset = 1'b1;
        op = opNop;
        srcA = '0;
        srcB = '0;
        shamt = '0;
        flush = 1'b0;
        commitBlock = 1'b0;
        lineNo = 0;
        testCount = 0;
        repeat (ResetCycles) @(negedge clk);
        reset = 1'b0;

        fd = $fopen("tests/execUnit_golden.txt", "r");
        if (fd == 0) begin
            $display("TEST FAILED");
            $fatal(1, "cannot open tests/execUnit_golden.txt");
        end
        while ($fgets(line, fd) != 0) begin
            lineNo++;
            // skip comments and blank lines
            if (line.len() > 1 && line.getc(0) != "#") begin
                fields = $sscanf(line, "%s %h %h %h %h %h %h %h %h", testName, opCode,
                                 a, b, sh, ctl, expResult, expOvf, expTrap);
                if (fields != 9) begin
                    $display("TEST FAILED");
                    $fatal(1, "golden line %0d is malformed", lineNo);
                end else begin
                    issueOp(opCode[5:0], a, b, sh[4:0], ctl[1:0]);
                    waitStallLow(testName, stallCycles);
                    // a flushed op is cut short
                    if (ctl[1:0] != 2'd1) begin
                        compareValue(testName, "stall cycles",
                                     expectedStallCycles(opCode[5:0]), stallCycles);
                    end
                    compareValue(testName, "result", expResult, result);
                    compareValue(testName, "overflow", expOvf, {31'b0, overflow});
                    compareValue(testName, "trap", expTrap, {31'b0, trap});
                    testCount++;
                end
            end
        end
        $fclose(fd);

        if (testCount == 0) begin
            $display("TEST FAILED");
            $fatal(1, "golden file held no test lines");
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

// ==== tests/execUnit_golden.txt ====
# name op srcA srcB shamt ctl result overflow trap, all values hex
# ctl 0 plain issue, 1 flush one cycle after start, 2 commit blocked
nop      00 13579bdf 00000000 00 0 13579bdf 0 0
and      01 f0f0ff00 0ff0f0f0 00 0 00f0f000 0 0
or       02 f0f0ff00 0ff0f0f0 00 0 fff0fff0 0 0
nor      03 f0f0ff00 0ff0f0f0 00 0 000f000f 0 0
xor      04 f0f0ff00 0ff0f0f0 00 0 ff000ff0 0 0
addOvf   05 7fffffff 00000001 00 0 80000000 1 0
addMax   05 7ffffffe 00000001 00 0 7fffffff 0 0
adduWrap 06 7fffffff 00000001 00 0 80000000 0 0
subOvf   07 80000000 00000001 00 0 7fffffff 1 0
subuWrap 08 80000000 00000001 00 0 7fffffff 0 0
slt      09 ffffffff 00000001 00 0 00000001 0 0
sltu     0a ffffffff 00000001 00 0 00000000 0 0
sll31    0b 00000000 00000003 1f 0 80000000 0 0
srl0     0c 00000000 80000001 00 0 80000001 0 0
sra31    0d 00000000 80000000 1f 0 ffffffff 0 0
sllv     0e 00000024 00000001 00 0 00000010 0 0
srlv     0f 0000001f 80000000 00 0 00000001 0 0
srav     10 00000004 f0000000 00 0 ff000000 0 0
lui      11 00000000 0000abcd 00 0 abcd0000 0 0
cloOnes  12 ffffffff 00000000 00 0 00000020 0 0
clo      12 f0000000 00000000 00 0 00000004 0 0
clzZero  13 00000000 00000000 00 0 00000020 0 0
clz      13 00010000 00000000 00 0 0000000f 0 0
movn     14 12345678 00000001 00 0 12345678 0 0
movz     15 12345678 00000001 00 0 00000000 0 0
teqHit   16 00000005 00000005 00 0 00000000 0 1
teqMiss  16 00000005 00000006 00 0 00000000 0 0
tneHit   17 00000005 00000006 00 0 00000000 0 1
tneMiss  17 00000005 00000005 00 0 00000000 0 0
tgeNeg   18 ffffffff 00000001 00 0 00000000 0 0
tgeuNeg  19 ffffffff 00000001 00 0 00000000 0 1
tltNeg   1a ffffffff 00000001 00 0 00000000 0 1
tltuNeg  1b ffffffff 00000001 00 0 00000000 0 0
tgePos   18 00000001 ffffffff 00 0 00000000 0 1
tgeuPos  19 00000001 ffffffff 00 0 00000000 0 0
tltPos   1a 00000001 ffffffff 00 0 00000000 0 0
tltuPos  1b 00000001 ffffffff 00 0 00000000 0 1
mult     1c fffffffe 00000003 00 0 00000000 0 0
multHi   27 00000000 00000000 00 0 ffffffff 0 0
multLo   28 00000000 00000000 00 0 fffffffa 0 0
multu    1d fffffffe 00000003 00 0 00000000 0 0
multuHi  27 00000000 00000000 00 0 00000002 0 0
multuLo  28 00000000 00000000 00 0 fffffffa 0 0
mul      1e fffffffe 00000003 00 0 fffffffa 0 0
mulHi    27 00000000 00000000 00 0 00000002 0 0
div      23 fffffff9 00000002 00 0 00000000 0 0
divHi    27 00000000 00000000 00 0 ffffffff 0 0
divLo    28 00000000 00000000 00 0 fffffffd 0 0
divuZero 24 00000007 00000000 00 0 00000000 0 0
divuHi   27 00000000 00000000 00 0 00000007 0 0
divuLo   28 00000000 00000000 00 0 ffffffff 0 0
mthi     25 00000001 00000000 00 0 00000000 0 0
mtlo     26 fffffffe 00000000 00 0 00000000 0 0
madd     1f 00000002 00000003 00 0 00000000 0 0
msub     21 ffffffff 00000004 00 0 00000000 0 0
maddu    20 ffffffff 00000002 00 0 00000000 0 0
msubu    22 00000003 00000002 00 0 00000000 0 0
accHi    27 00000000 00000000 00 0 00000004 0 0
accLo    28 00000000 00000000 00 0 00000000 0 0
divFlush 23 00000064 00000003 00 1 00000000 0 0
flushHi  27 00000000 00000000 00 0 00000004 0 0
flushLo  28 00000000 00000000 00 0 00000000 0 0
mtloBlk  26 deadbeef 00000000 00 2 00000000 0 0
blockLo  28 00000000 00000000 00 0 00000000 0 0

// ==== execUnit.f ====
hw/execPkg.sv
hw/aluCore.sv
hw/mulUnit.sv
hw/divUnit.sv
hw/hiLoRegs.sv
hw/execUnit.sv
tests/execUnit_checker.sv
tests/execUnitTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= execUnitTb
FILELIST  ?= execUnit.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --assert --timing --timescale 1ns/1ps

SIM     := $(OBJDIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJDIR)
